// File: verilog/intra4_pkg.sv
/*
 * Intra 4x4 luma mode decision, shared definitions
 * Pixel geometry, mode and state encodings, fixed mode costs
 */
`default_nettype none

package intra4_pkg;

    localparam int PIX_W     = 8;
    localparam int SUB_PIX   = 16;
    localparam int NUM_SUB   = 16;
    localparam int NUM_MODES = 4;
    localparam int SSE_W     = 32;
    localparam int SCORE_W   = 64;
    localparam int HDR_COST  = 211;

    // One top row or left column, pixel 0 in the low byte
    typedef logic [4*PIX_W-1:0] edge4_t;

    // 4x4 pixels in raster order
    typedef logic [SUB_PIX*PIX_W-1:0] blk4_t;

    typedef enum logic [1:0] {
        DC = 2'd0,
        TM = 2'd1,
        VE = 2'd2,
        HE = 2'd3
    } pred_mode_e;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        EVAL,
        PICK,
        STORE,
        NEXT,
        DONE
    } ctrl_state_e;

    // Fixed header cost per mode
    function automatic logic [10:0] mode_cost(input pred_mode_e mode);
        case (mode)
            DC:      mode_cost = 11'd40;
            TM:      mode_cost = 11'd1151;
            VE:      mode_cost = 11'd1723;
            default: mode_cost = 11'd1874;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: verilog/nbr_if.sv
/*
 * Current subblock bundle
 * Source pixels plus top, left and corner neighbours
 */
`default_nettype none

interface nbr_if;

    intra4_pkg::blk4_t                 src4;
    intra4_pkg::edge4_t                top4;
    intra4_pkg::edge4_t                left4;
    logic [intra4_pkg::PIX_W-1:0]      top_left;

    modport ctx  (output src4, top4, left4, top_left);
    modport pred (input top4, left4, top_left);
    modport meas (input src4);

endinterface

`default_nettype wire

// File: verilog/block_ctx.sv
/*
 * Subblock context
 * Picks source and neighbours of the current 4x4 subblock and
 * keeps the reconstructed macroblock and the chosen modes
 */
`default_nettype none

module block_ctx (
    input  wire logic                                                      clk,
    input  wire logic                                                      rst_n,
    input  wire logic [$clog2(intra4_pkg::NUM_SUB)-1:0]                    sub_idx_i,
    input  wire logic                                                      store_i,
    input  intra4_pkg::pred_mode_e                                         best_mode_i,
    input  intra4_pkg::blk4_t                                pred_i [intra4_pkg::NUM_MODES],
    input  wire logic [intra4_pkg::NUM_SUB*intra4_pkg::SUB_PIX*intra4_pkg::PIX_W-1:0] src_i,
    input  wire logic [16*intra4_pkg::PIX_W-1:0]                           top_i,
    input  wire logic [16*intra4_pkg::PIX_W-1:0]                           left_i,
    input  wire logic [intra4_pkg::PIX_W-1:0]                              top_left_i,
    nbr_if.ctx                                                             nbr,
    output logic [intra4_pkg::NUM_SUB*intra4_pkg::SUB_PIX*intra4_pkg::PIX_W-1:0] rec_o,
    output logic [2*intra4_pkg::NUM_SUB-1:0]                               modes_o
);

    intra4_pkg::blk4_t      rec_sub [intra4_pkg::NUM_SUB];
    intra4_pkg::pred_mode_e mode_q  [intra4_pkg::NUM_SUB];

    logic [1:0] row;
    logic [1:0] col;

    assign row = sub_idx_i[3:2];
    assign col = sub_idx_i[1:0];

    // ------------------------------
    // Neighbour selection
    // ------------------------------
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            nbr.src4[k*32 +: 32] = src_i[((4*row + k)*16 + 4*col)*intra4_pkg::PIX_W +: 32];
        end

        if (row == 2'd0) begin
            nbr.top4 = top_i[col*32 +: 32];
        end else begin
            // Bottom row of the subblock above
            nbr.top4 = rec_sub[sub_idx_i - 4'd4][96 +: 32];
        end

        if (col == 2'd0) begin
            nbr.left4 = left_i[row*32 +: 32];
        end else begin
            // Right column of the subblock to the left
            for (int k = 0; k < 4; k++) begin
                nbr.left4[k*8 +: 8] = rec_sub[sub_idx_i - 4'd1][(4*k + 3)*8 +: 8];
            end
        end

        if (row == 2'd0 && col == 2'd0) begin
            nbr.top_left = top_left_i;
        end else if (row == 2'd0) begin
            nbr.top_left = top_i[(4*col - 1)*8 +: 8];
        end else if (col == 2'd0) begin
            nbr.top_left = left_i[(4*row - 1)*8 +: 8];
        end else begin
            nbr.top_left = rec_sub[sub_idx_i - 4'd5][15*8 +: 8];
        end
    end

    // ------------------------------
    // Reconstruction and mode store
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < intra4_pkg::NUM_SUB; i++) begin
                rec_sub[i] <= '0;
                mode_q[i]  <= intra4_pkg::DC;
            end
        end else if (store_i) begin
            rec_sub[sub_idx_i] <= pred_i[best_mode_i];
            mode_q[sub_idx_i]  <= best_mode_i;
        end
    end

    // Back to macroblock raster order
    for (genvar i = 0; i < intra4_pkg::NUM_SUB; i++) begin : g_out
        for (genvar k = 0; k < 4; k++) begin : g_row
            assign rec_o[((4*(i/4) + k)*16 + 4*(i%4))*8 +: 32] = rec_sub[i][k*32 +: 32];
        end
        assign modes_o[2*i +: 2] = mode_q[i];
    end

endmodule

`default_nettype wire

// File: verilog/intra4_predict.sv
/*
 * 4x4 intra predictors
 * DC, TrueMotion, vertical and horizontal, all combinational
 */
`default_nettype none

module intra4_predict (
    nbr_if.pred                 nbr,
    output intra4_pkg::blk4_t   pred_o [intra4_pkg::NUM_MODES]
);

    logic [intra4_pkg::PIX_W+2:0] dc_sum;
    logic [intra4_pkg::PIX_W-1:0] dc_val;

    // Eight neighbours plus rounding
    always_comb begin
        dc_sum = 11'd4;
        for (int j = 0; j < 4; j++) begin
            dc_sum = dc_sum + {3'b000, nbr.top4[j*8 +: 8]} + {3'b000, nbr.left4[j*8 +: 8]};
        end
    end

    assign dc_val = dc_sum[10:3];

    assign pred_o[intra4_pkg::DC] = {intra4_pkg::SUB_PIX{dc_val}};

    // Every row repeats the top edge
    assign pred_o[intra4_pkg::VE] = {4{nbr.top4}};

    always_comb begin
        for (int y = 0; y < 4; y++) begin
            pred_o[intra4_pkg::HE][y*32 +: 32] = {4{nbr.left4[y*8 +: 8]}};
        end
    end

    // ------------------------------
    // TrueMotion with clipping
    // ------------------------------
    always_comb begin
        logic signed [intra4_pkg::PIX_W+1:0] tm;
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                tm = $signed({2'b00, nbr.top4[x*8 +: 8]})
                   + $signed({2'b00, nbr.left4[y*8 +: 8]})
                   - $signed({2'b00, nbr.top_left});
                if (tm[9]) begin
                    pred_o[intra4_pkg::TM][(y*4 + x)*8 +: 8] = 8'h00;
                end else if (tm[8]) begin
                    pred_o[intra4_pkg::TM][(y*4 + x)*8 +: 8] = 8'hff;
                end else begin
                    pred_o[intra4_pkg::TM][(y*4 + x)*8 +: 8] = tm[7:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/sse4_accum.sv
/*
 * Row-serial SSE unit
 * One row per cycle for all four predictions in parallel
 */
`default_nettype none

module sse4_accum (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           eval_start_i,
    nbr_if.meas                                 nbr,
    input  intra4_pkg::blk4_t                   pred_i [intra4_pkg::NUM_MODES],
    output logic [intra4_pkg::SSE_W-1:0]        sse_o  [intra4_pkg::NUM_MODES],
    output logic                                sse_done_o
);

    logic [1:0]  row_q;
    logic [1:0]  sel_row;
    logic        busy_q;
    logic [17:0] row_sse [intra4_pkg::NUM_MODES];

    assign sel_row = eval_start_i ? 2'd0 : row_q;

    // Squared error of the selected row
    always_comb begin
        logic [7:0]  ad;
        logic [15:0] sq;
        for (int m = 0; m < intra4_pkg::NUM_MODES; m++) begin
            row_sse[m] = '0;
            for (int x = 0; x < 4; x++) begin
                if (nbr.src4[(sel_row*4 + x)*8 +: 8] > pred_i[m][(sel_row*4 + x)*8 +: 8]) begin
                    ad = nbr.src4[(sel_row*4 + x)*8 +: 8] - pred_i[m][(sel_row*4 + x)*8 +: 8];
                end else begin
                    ad = pred_i[m][(sel_row*4 + x)*8 +: 8] - nbr.src4[(sel_row*4 + x)*8 +: 8];
                end
                sq = {8'h00, ad} * {8'h00, ad};
                row_sse[m] = row_sse[m] + {2'b00, sq};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q      <= 2'd0;
            busy_q     <= 1'b0;
            sse_done_o <= 1'b0;
        end else begin
            sse_done_o <= busy_q && (row_q == 2'd3);
            if (eval_start_i) begin
                row_q  <= 2'd1;
                busy_q <= 1'b1;
            end else if (busy_q) begin
                row_q <= row_q + 2'd1;
                if (row_q == 2'd3) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Accumulators hold after the last row
    always_ff @(posedge clk) begin
        for (int m = 0; m < intra4_pkg::NUM_MODES; m++) begin
            if (eval_start_i) begin
                sse_o[m] <= intra4_pkg::SSE_W'(row_sse[m]);
            end else if (busy_q) begin
                sse_o[m] <= sse_o[m] + intra4_pkg::SSE_W'(row_sse[m]);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/mode_select.sv
/*
 * Rate-distortion mode choice
 * Score is 256 * SSE + lambda * mode cost, lowest wins
 */
`default_nettype none

module mode_select #(
    parameter int LAMBDA_W = 16
) (
    input  wire logic [LAMBDA_W-1:0]            lambda_i,
    input  wire logic [intra4_pkg::SSE_W-1:0]   sse_i [intra4_pkg::NUM_MODES],
    output intra4_pkg::pred_mode_e              best_mode_o,
    output logic [intra4_pkg::SCORE_W-1:0]      best_score_o
);

    logic [intra4_pkg::SCORE_W-1:0] score [intra4_pkg::NUM_MODES];

    always_comb begin
        for (int m = 0; m < intra4_pkg::NUM_MODES; m++) begin
            score[m] = (intra4_pkg::SCORE_W'(sse_i[m]) << 8)
                     + intra4_pkg::SCORE_W'(lambda_i)
                     * intra4_pkg::SCORE_W'(intra4_pkg::mode_cost(
                           intra4_pkg::pred_mode_e'(2'(m))));
        end
    end

    // Strict compare keeps the lower index on a tie
    always_comb begin
        best_mode_o  = intra4_pkg::DC;
        best_score_o = score[0];
        for (int m = 1; m < intra4_pkg::NUM_MODES; m++) begin
            if (score[m] < best_score_o) begin
                best_mode_o  = intra4_pkg::pred_mode_e'(2'(m));
                best_score_o = score[m];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/intra4_ctrl.sv
/*
 * Subblock walk controller
 * Steps the sixteen subblocks and sums the macroblock score
 */
`default_nettype none

module intra4_ctrl #(
    parameter int LAMBDA_W = 16
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   start_i,
    input  wire logic [LAMBDA_W-1:0]                    lambda_i,
    input  wire logic                                   sse_done_i,
    input  intra4_pkg::pred_mode_e                      best_mode_i,
    input  wire logic [intra4_pkg::SCORE_W-1:0]         best_score_i,
    output logic [$clog2(intra4_pkg::NUM_SUB)-1:0]      sub_idx_o,
    output logic                                        eval_start_o,
    output logic                                        store_o,
    output intra4_pkg::pred_mode_e                      best_mode_o,
    output logic [intra4_pkg::SCORE_W-1:0]              score_o,
    output logic                                        done_o
);

    intra4_pkg::ctrl_state_e state_q;
    intra4_pkg::ctrl_state_e state_d;

    logic [intra4_pkg::SCORE_W-1:0] score_acc;

    // ------------------------------
    // State machine
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            intra4_pkg::IDLE:  if (start_i) state_d = intra4_pkg::LOAD;
            intra4_pkg::LOAD:  state_d = intra4_pkg::EVAL;
            intra4_pkg::EVAL:  if (sse_done_i) state_d = intra4_pkg::PICK;
            intra4_pkg::PICK:  state_d = intra4_pkg::STORE;
            intra4_pkg::STORE: state_d = intra4_pkg::NEXT;
            intra4_pkg::NEXT: begin
                if (sub_idx_o == 4'(intra4_pkg::NUM_SUB - 1)) begin
                    state_d = intra4_pkg::DONE;
                end else begin
                    state_d = intra4_pkg::LOAD;
                end
            end
            default:           state_d = intra4_pkg::IDLE;
        endcase
    end

    assign eval_start_o = (state_q == intra4_pkg::LOAD);
    assign store_o      = (state_q == intra4_pkg::STORE);
    assign done_o       = (state_q == intra4_pkg::DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= intra4_pkg::IDLE;
            sub_idx_o   <= '0;
            best_mode_o <= intra4_pkg::DC;
            score_acc   <= '0;
            score_o     <= '0;
        end else begin
            state_q <= state_d;
            case (state_q)
                intra4_pkg::IDLE: begin
                    if (start_i) begin
                        score_acc <= intra4_pkg::SCORE_W'(intra4_pkg::HDR_COST)
                                   * intra4_pkg::SCORE_W'(lambda_i);
                    end
                end
                intra4_pkg::PICK:  best_mode_o <= best_mode_i;
                intra4_pkg::STORE: begin
                    // Published total follows the running sum
                    score_acc <= score_acc + best_score_i;
                    score_o   <= score_acc + best_score_i;
                end
                // Wraps back to zero after the last subblock
                intra4_pkg::NEXT:  sub_idx_o <= sub_idx_o + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/intra4_pick.sv
/*
 * Intra 4x4 luma mode decision for one 16x16 macroblock
 * Returns the reconstruction, sixteen modes and the total score
 */
`default_nettype none

module intra4_pick #(
    parameter int LAMBDA_W = 16
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   start_i,
    input  wire logic [LAMBDA_W-1:0]                    lambda_i,
    input  wire logic [256*intra4_pkg::PIX_W-1:0]       src_i,
    input  wire logic [16*intra4_pkg::PIX_W-1:0]        top_i,
    input  wire logic [16*intra4_pkg::PIX_W-1:0]        left_i,
    input  wire logic [intra4_pkg::PIX_W-1:0]           top_left_i,
    output logic [256*intra4_pkg::PIX_W-1:0]            rec_o,
    output logic [2*intra4_pkg::NUM_SUB-1:0]            modes_o,
    output logic [intra4_pkg::SCORE_W-1:0]              score_o,
    output logic                                        done_o
);

    nbr_if nbr_bus ();

    intra4_pkg::blk4_t                          pred [intra4_pkg::NUM_MODES];
    logic [intra4_pkg::SSE_W-1:0]               sse  [intra4_pkg::NUM_MODES];
    logic [$clog2(intra4_pkg::NUM_SUB)-1:0]     sub_idx;
    logic                                       eval_start;
    logic                                       sse_done;
    logic                                       store;
    intra4_pkg::pred_mode_e                     cand_mode;
    logic [intra4_pkg::SCORE_W-1:0]             cand_score;
    intra4_pkg::pred_mode_e                     best_mode;

    block_ctx u_ctx (
        .clk         (clk),
        .rst_n       (rst_n),
        .sub_idx_i   (sub_idx),
        .store_i     (store),
        .best_mode_i (best_mode),
        .pred_i      (pred),
        .src_i       (src_i),
        .top_i       (top_i),
        .left_i      (left_i),
        .top_left_i  (top_left_i),
        .nbr         (nbr_bus.ctx),
        .rec_o       (rec_o),
        .modes_o     (modes_o)
    );

    intra4_predict u_pred (
        .nbr    (nbr_bus.pred),
        .pred_o (pred)
    );

    sse4_accum u_sse (
        .clk          (clk),
        .rst_n        (rst_n),
        .eval_start_i (eval_start),
        .nbr          (nbr_bus.meas),
        .pred_i       (pred),
        .sse_o        (sse),
        .sse_done_o   (sse_done)
    );

    mode_select #(.LAMBDA_W(LAMBDA_W)) u_sel (
        .lambda_i     (lambda_i),
        .sse_i        (sse),
        .best_mode_o  (cand_mode),
        .best_score_o (cand_score)
    );

    intra4_ctrl #(.LAMBDA_W(LAMBDA_W)) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .lambda_i     (lambda_i),
        .sse_done_i   (sse_done),
        .best_mode_i  (cand_mode),
        .best_score_i (cand_score),
        .sub_idx_o    (sub_idx),
        .eval_start_o (eval_start),
        .store_o      (store),
        .best_mode_o  (best_mode),
        .score_o      (score_o),
        .done_o       (done_o)
    );

endmodule

`default_nettype wire

// File: test/tb_clock.sv
/*
 * Testbench clock source
 */
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_intra4_pick.sv
/*
 * Testbench for the intra 4x4 luma mode decision
 * Random macroblocks checked against a pixel-level model
 */
`default_nettype none

module tb_intra4_pick;

    localparam int LAMBDA_W     = 16;
    localparam int NUM_RANDOM   = 20;
    localparam int NUM_RUNS     = NUM_RANDOM + 3;
    localparam int WATCHDOG_CYC = 100 * 16 * NUM_RUNS;

    logic                clk;
    logic                rst_n;
    logic                start_i;
    logic [LAMBDA_W-1:0] lambda_i;
    logic [2047:0]       src_i;
    logic [127:0]        top_i;
    logic [127:0]        left_i;
    logic [7:0]          top_left_i;
    logic [2047:0]       rec_o;
    logic [31:0]         modes_o;
    logic [63:0]         score_o;
    logic                done_o;

    integer seed;
    int     done_count = 0;
    int     count_before;
    int     cost_tab [4] = '{40, 1151, 1723, 1874};

    // Model inputs as one byte per pixel
    logic [7:0]          src_pix  [256];
    logic [7:0]          top_pix  [16];
    logic [7:0]          left_pix [16];
    logic [7:0]          corner;
    logic [LAMBDA_W-1:0] lambda;

    logic [2047:0]       exp_rec;
    logic [31:0]         exp_modes;
    logic [63:0]         exp_score;

    tb_clock #(.PERIOD(10)) clk_gen (.clk_o(clk));

    intra4_pick #(.LAMBDA_W(LAMBDA_W)) intra4_pick_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .lambda_i   (lambda_i),
        .src_i      (src_i),
        .top_i      (top_i),
        .left_i     (left_i),
        .top_left_i (top_left_i),
        .rec_o      (rec_o),
        .modes_o    (modes_o),
        .score_o    (score_o),
        .done_o     (done_o)
    );

    task automatic check_value(input string name, input logic [2047:0] got,
                               input logic [2047:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Stopping at first error");
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic compute_expected();
        int              rec  [256];
        int              top  [4];
        int              left [4];
        int              pred [4][16];
        int              r, c, tl, dc, v, d, best, pos;
        longint unsigned sse, score, best_score;
        exp_score = 64'(211) * 64'(lambda);
        for (int i4 = 0; i4 < 16; i4++) begin
            r = i4 / 4;
            c = i4 % 4;
            for (int k = 0; k < 4; k++) begin
                top[k]  = (r == 0) ? int'(top_pix[4*c + k]) : rec[(4*r - 1)*16 + 4*c + k];
                left[k] = (c == 0) ? int'(left_pix[4*r + k]) : rec[(4*r + k)*16 + 4*c - 1];
            end
            if (r == 0 && c == 0) begin
                tl = corner;
            end else if (r == 0) begin
                tl = top_pix[4*c - 1];
            end else if (c == 0) begin
                tl = left_pix[4*r - 1];
            end else begin
                tl = rec[(4*r - 1)*16 + 4*c - 1];
            end
            dc = 4;
            for (int k = 0; k < 4; k++) begin
                dc = dc + top[k] + left[k];
            end
            dc = dc / 8;
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    v = top[x] + left[y] - tl;
                    pred[0][4*y + x] = dc;
                    pred[1][4*y + x] = (v < 0) ? 0 : ((v > 255) ? 255 : v);
                    pred[2][4*y + x] = top[x];
                    pred[3][4*y + x] = left[y];
                end
            end
            best       = 0;
            best_score = 0;
            for (int m = 0; m < 4; m++) begin
                sse = 0;
                for (int p = 0; p < 16; p++) begin
                    d   = int'(src_pix[(4*r + p/4)*16 + 4*c + p%4]) - pred[m][p];
                    sse = sse + longint'(d * d);
                end
                score = (sse << 8) + longint'(lambda) * longint'(cost_tab[m]);
                // Lower index keeps a tie
                if (m == 0 || score < best_score) begin
                    best       = m;
                    best_score = score;
                end
            end
            exp_score = exp_score + best_score;
            exp_modes[2*i4 +: 2] = 2'(best);
            for (int p = 0; p < 16; p++) begin
                pos = (4*r + p/4)*16 + 4*c + p%4;
                rec[pos] = pred[best][p];
                exp_rec[pos*8 +: 8] = 8'(pred[best][p]);
            end
        end
    endtask

    // ------------------------------
    // Stimulus and result collection
    // ------------------------------
    task automatic random_block();
        for (int i = 0; i < 256; i++) begin
            src_pix[i] = 8'($random(seed));
        end
        for (int i = 0; i < 16; i++) begin
            top_pix[i]  = 8'($random(seed));
            left_pix[i] = 8'($random(seed));
        end
        corner = 8'($random(seed));
        lambda = LAMBDA_W'($random(seed)) & LAMBDA_W'(16'h01ff);
    endtask

    task automatic start_run();
        logic [2047:0] src_v;
        logic [127:0]  top_v;
        logic [127:0]  left_v;
        for (int i = 0; i < 256; i++) begin
            src_v[i*8 +: 8] = src_pix[i];
        end
        for (int i = 0; i < 16; i++) begin
            top_v[i*8 +: 8]  = top_pix[i];
            left_v[i*8 +: 8] = left_pix[i];
        end
        @(posedge clk);
        src_i      <= src_v;
        top_i      <= top_v;
        left_i     <= left_v;
        top_left_i <= corner;
        lambda_i   <= lambda;
        start_i    <= 1'b1;
        @(posedge clk);
        start_i    <= 1'b0;
    endtask

    task automatic check_results();
        @(negedge clk);
        while (done_o !== 1'b1) begin
            @(negedge clk);
        end
        check_value("rec_o", rec_o, exp_rec);
        check_value("modes_o", modes_o, exp_modes);
        check_value("score_o", score_o, exp_score);
        // Single-cycle done pulse
        @(negedge clk);
        check_value("done_o", done_o, 1'b0);
    endtask

    task automatic run_block();
        compute_expected();
        start_run();
        check_results();
    endtask

    always @(posedge clk) begin
        if (rst_n && done_o === 1'b1) begin
            done_count <= done_count + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Timeout: no result within %0d clock cycles", WATCHDOG_CYC);
        $display("Test failed");
        $fatal(1, "Simulation stopped by watchdog");
    end

    initial begin
        logic [7:0] flat;
        logic [7:0] stripe [4];
        seed       = 32'h57d6_a755;
        rst_n      = 1'b0;
        start_i    = 1'b0;
        lambda_i   = '0;
        src_i      = '0;
        top_i      = '0;
        left_i     = '0;
        top_left_i = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Outputs straight after reset
        @(negedge clk);
        check_value("done_o", done_o, 1'b0);
        check_value("rec_o", rec_o, '0);
        check_value("modes_o", modes_o, '0);
        check_value("score_o", score_o, '0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_block();
            run_block();
        end

        // Flat block where every mode is exact and DC wins on cost
        flat   = 8'($random(seed));
        lambda = LAMBDA_W'($random(seed));
        foreach (src_pix[i]) begin
            src_pix[i] = flat;
        end
        foreach (top_pix[i]) begin
            top_pix[i] = flat;
        end
        foreach (left_pix[i]) begin
            left_pix[i] = flat;
        end
        corner = flat;
        run_block();
        check_value("modes_o", modes_o, 32'h0);
        check_value("score_o", score_o, 64'(851) * 64'(lambda));

        // Vertical stripes with zero lambda where TM and VE tie at zero SSE
        flat      = 8'($random(seed));
        stripe[0] = 8'($random(seed));
        for (int x = 1; x < 4; x++) begin
            stripe[x] = stripe[0] + 8'(40 * x);
        end
        foreach (src_pix[i]) begin
            src_pix[i] = stripe[i % 4];
        end
        foreach (top_pix[i]) begin
            top_pix[i] = stripe[i % 4];
        end
        foreach (left_pix[i]) begin
            left_pix[i] = flat;
        end
        corner = flat;
        lambda = '0;
        run_block();
        check_value("modes_o", modes_o, 32'h5555_5555);
        check_value("score_o", score_o, 64'h0);

        // Second start while busy must be ignored
        random_block();
        count_before = done_count;
        compute_expected();
        start_run();
        repeat (30) @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        check_results();
        repeat (150) @(negedge clk);
        check_value("done_o pulse count", done_count, count_before + 1);

        check_value("done_o pulse count", done_count, NUM_RUNS);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/intra4_pkg.sv
verilog/nbr_if.sv
verilog/block_ctx.sv
verilog/intra4_predict.sv
verilog/sse4_accum.sv
verilog/mode_select.sv
verilog/intra4_ctrl.sv
verilog/intra4_pick.sv
test/tb_clock.sv
test/tb_intra4_pick.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the intra 4x4 mode decision testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_intra4_pick \
    -f filelist.f --Mdir obj_dir \
    && ./obj_dir/Vtb_intra4_pick 2>&1 | tee sim.log

grep -qs "^Test passed$" sim.log && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
